// ==== rtl/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// word width of features, weights and a, b, c
`define FEAT_W 16

// fraction bits
`define IN_FT_QUAZ_ACC 10 // features and weights
`define AB_QUAZ_ACC 12    // scale a
`define C_QUAZ_ACC 14     // leaky slope c

// conv result before the linear stage
`define CONV_RES_W 32

// line memory depth, widest map supported
`define MAX_MAP_W 512

// elastic buffer between mac and activation
`define RES_FIFO_DEPTH 16

// register write port
`define REG_ADDR_W 4

`endif

// ==== rtl/conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

	typedef logic signed [`FEAT_W-1:0] feat_t;

	// input stream beat
	typedef struct packed {
		logic  last; // final pixel of the frame
		feat_t data;
	} pixel_t;

	// px[r*3+c], row 0 is the oldest row, col 2 the newest pixel
	typedef struct packed {
		logic       last;
		feat_t [8:0] px;
	} window_t;

	typedef struct packed {
		logic                          last;
		logic signed [`CONV_RES_W-1:0] data;
	} conv_res_t;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] addr;
		logic [`FEAT_W-1:0]     data;
	} reg_wr_t;

	typedef enum logic [`REG_ADDR_W-1:0] {
		REG_K0 = 4'd0,
		REG_K1, REG_K2, REG_K3, REG_K4, REG_K5, REG_K6, REG_K7,
		REG_K8 = 4'd8,
		REG_A = 4'd9,
		REG_B = 4'd10,
		REG_C = 4'd11,
		REG_MAP_W = 4'd12, // width minus 1
		REG_EN = 4'd13
	} reg_addr_e;

	typedef struct packed {
		feat_t [8:0]        w;        // kernel, row-major
		feat_t              a;
		feat_t              b;
		feat_t              c;
		logic [`FEAT_W-1:0] map_w_m1;
		logic               en;
	} conv_params_t;

endpackage

// ==== rtl/conv_param_regs.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_param_regs import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         cfg_valid,
	input  reg_wr_t      cfg,
	output conv_params_t params
);

	// one field per write, no readback
	always_ff @(posedge clk) begin
		if (rst) begin
			params <= '0; // also leaves the core disabled
		end else if (cfg_valid) begin
			case (cfg.addr)
				REG_K0,
				REG_K1,
				REG_K2,
				REG_K3,
				REG_K4,
				REG_K5,
				REG_K6,
				REG_K7,
				REG_K8: begin
					params.w[cfg.addr] <= cfg.data;
				end
				REG_A: begin
					params.a <= cfg.data;
				end
				REG_B: begin
					params.b <= cfg.data;
				end
				REG_C: begin
					params.c <= cfg.data;
				end
				REG_MAP_W: begin
					params.map_w_m1 <= cfg.data;
				end
				REG_EN: begin
					params.en <= cfg.data[0];
				end
				default: begin
					// unmapped addresses dropped
				end
			endcase
		end
	end

endmodule

// ==== rtl/line_window_buffer.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module line_window_buffer import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  conv_params_t params,
	input  logic         s_valid,
	input  pixel_t       s_pix,
	output logic         s_ready,
	output logic         win_valid,
	output window_t      win,
	input  logic         win_ready
);

	localparam int COL_W = $clog2(`MAX_MAP_W);

	feat_t line0 [`MAX_MAP_W]; // row above the current one
	feat_t line1 [`MAX_MAP_W]; // two rows above
	feat_t new_col [3];        // top to bottom

	logic [COL_W-1:0] col;
	logic [1:0]       row; // stops counting at 2
	logic             accept;
	logic             row_end;
	logic             interior;

	// a held window blocks further input
	assign s_ready = params.en & (~win_valid | win_ready);
	assign accept = s_valid & s_ready;

	assign row_end = col == params.map_w_m1[COL_W-1:0];
	assign interior = (col >= COL_W'(2)) && (row == 2'd2);

	assign new_col[0] = line1[col];
	assign new_col[1] = line0[col];
	assign new_col[2] = s_pix.data;

	// each column slot moves down one line per accepted pixel
	always_ff @(posedge clk) begin
		if (accept) begin
			line0[col] <= s_pix.data;
			line1[col] <= line0[col];
		end
	end

	// window shifts left, fresh column enters at the right
	always_ff @(posedge clk) begin
		if (accept) begin
			for (int r = 0; r < 3; r++) begin
				win.px[r*3] <= win.px[r*3+1];
				win.px[r*3+1] <= win.px[r*3+2];
				win.px[r*3+2] <= new_col[r];
			end
			win.last <= s_pix.last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
			win_valid <= 1'b0;
		end else begin
			if (accept) begin
				win_valid <= interior;
			end else if (win_ready) begin
				win_valid <= 1'b0;
			end

			if (accept) begin
				if (s_pix.last) begin
					// frame done, next pixel starts at the top left
					col <= '0;
					row <= '0;
				end else if (row_end) begin
					col <= '0;
					if (row != 2'd2) begin
						row <= row + 2'd1;
					end
				end else begin
					col <= col + COL_W'(1);
				end
			end
		end
	end

endmodule

// ==== rtl/conv_mac_3x3.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_mac_3x3 import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  conv_params_t params,
	input  logic         win_valid,
	input  window_t      win,
	output logic         win_ready,
	output logic         mac_valid,
	output conv_res_t    mac_res,
	input  logic         mac_ready
);

	localparam int PROD_W = 2 * `FEAT_W;
	localparam int SUM_W = PROD_W + 4; // nine terms need 4 more bits

	logic signed [PROD_W-1:0] prod [9];
	logic signed [SUM_W-1:0]  sum;
	logic                     s1_valid;
	logic                     s1_last;
	logic                     advance;

	// both stages move together or not at all
	assign advance = ~mac_valid | mac_ready;
	assign win_ready = advance;

	// stage 1 products
	always_ff @(posedge clk) begin
		if (advance) begin
			for (int i = 0; i < 9; i++) begin
				prod[i] <= $signed(win.px[i]) * $signed(params.w[i]);
			end
			s1_last <= win.last;
		end
	end

	// adder tree
	always_comb begin
		sum = '0;
		for (int i = 0; i < 9; i++) begin
			sum = sum + prod[i];
		end
	end

	// stage 2, back to feature scale
	always_ff @(posedge clk) begin
		if (advance) begin
			mac_res.data <= `CONV_RES_W'(sum >>> `IN_FT_QUAZ_ACC);
			mac_res.last <= s1_last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			mac_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= win_valid;
			mac_valid <= s1_valid;
		end
	end

endmodule

// ==== rtl/result_fifo.sv ====
`timescale 1ns/100ps

module result_fifo import conv_pkg::*; #(
	parameter int DEPTH = 16 // power of two
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      wr_valid,
	input  conv_res_t wr_data,
	output logic      wr_ready,
	output logic      rd_valid,
	output conv_res_t rd_data,
	input  logic      rd_ready
);

	localparam int AW = $clog2(DEPTH);

	conv_res_t      mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [AW:0]    count; // one extra bit to tell full from empty
	logic           wr_en;
	logic           rd_en;

	assign wr_ready = count != (AW+1)'(DEPTH);
	assign rd_valid = count != '0;
	assign rd_data = mem[rd_ptr];

	assign wr_en = wr_valid & wr_ready;
	assign rd_en = rd_valid & rd_ready;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + AW'(1); // wraps at DEPTH
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + AW'(1);
			end
			if (wr_en && !rd_en) begin
				count <= count + (AW+1)'(1);
			end else if (rd_en && !wr_en) begin
				count <= count - (AW+1)'(1);
			end
		end
	end

endmodule

// ==== rtl/linear_act_unit.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module linear_act_unit import conv_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  conv_params_t params,
	input  logic         s_valid,
	input  conv_res_t    s_res,
	output logic         s_ready,
	output logic         m_valid,
	output feat_t        m_data,
	output logic         m_last,
	input  logic         m_ready
);

	localparam int AX_W = `CONV_RES_W + `FEAT_W;
	localparam int ACT_W = AX_W + `FEAT_W;
	localparam logic signed [ACT_W-1:0] SAT_MAX = (ACT_W'(1) <<< (`FEAT_W-1)) - ACT_W'(1);
	localparam logic signed [ACT_W-1:0] SAT_MIN = -(ACT_W'(1) <<< (`FEAT_W-1));

	logic signed [AX_W-1:0]  ax;
	logic signed [AX_W-1:0]  y;
	logic signed [ACT_W-1:0] yc;
	logic signed [ACT_W-1:0] act;
	feat_t                   y_sat;

	always_comb begin
		ax = $signed(s_res.data) * $signed(params.a);
		y = (ax >>> `AB_QUAZ_ACC) + $signed(params.b);
		yc = y * $signed(params.c);
		if (y < 0) begin
			act = yc >>> `C_QUAZ_ACC; // leaky branch
		end else begin
			act = y;
		end
		if (act > SAT_MAX) begin
			y_sat = SAT_MAX[`FEAT_W-1:0];
		end else if (act < SAT_MIN) begin
			y_sat = SAT_MIN[`FEAT_W-1:0];
		end else begin
			y_sat = act[`FEAT_W-1:0];
		end
	end

	// output register, held while m_ready is low
	assign s_ready = ~m_valid | m_ready;

	always_ff @(posedge clk) begin
		if (s_ready && s_valid) begin
			m_data <= y_sat;
			m_last <= s_res.last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			m_valid <= 1'b0;
		end else if (s_ready) begin
			m_valid <= s_valid;
		end
	end

endmodule

// ==== rtl/conv_core_top.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_core_top import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    cfg_valid,
	input  reg_wr_t cfg,
	input  logic    s_valid,
	input  pixel_t  s_pix,
	output logic    s_ready,
	output logic    m_valid,
	output feat_t   m_data,
	output logic    m_last,
	input  logic    m_ready
);

	conv_params_t params;

	window_t   win;
	logic      win_valid;
	logic      win_ready;

	conv_res_t mac_res;
	logic      mac_valid;
	logic      mac_ready; // fifo not full

	conv_res_t fifo_res;
	logic      fifo_valid;
	logic      fifo_ready;

	conv_param_regs u_regs (
		.clk(clk),
		.rst(rst),
		.cfg_valid(cfg_valid),
		.cfg(cfg),
		.params(params)
	);

	// producer
	line_window_buffer u_win (
		.clk(clk),
		.rst(rst),
		.params(params),
		.s_valid(s_valid),
		.s_pix(s_pix),
		.s_ready(s_ready),
		.win_valid(win_valid),
		.win(win),
		.win_ready(win_ready)
	);

	conv_mac_3x3 u_mac (
		.clk(clk),
		.rst(rst),
		.params(params),
		.win_valid(win_valid),
		.win(win),
		.win_ready(win_ready),
		.mac_valid(mac_valid),
		.mac_res(mac_res),
		.mac_ready(mac_ready)
	);

	result_fifo #(
		.DEPTH(`RES_FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.wr_valid(mac_valid),
		.wr_data(mac_res),
		.wr_ready(mac_ready),
		.rd_valid(fifo_valid),
		.rd_data(fifo_res),
		.rd_ready(fifo_ready)
	);

	// consumer
	linear_act_unit u_act (
		.clk(clk),
		.rst(rst),
		.params(params),
		.s_valid(fifo_valid),
		.s_res(fifo_res),
		.s_ready(fifo_ready),
		.m_valid(m_valid),
		.m_data(m_data),
		.m_last(m_last),
		.m_ready(m_ready)
	);

endmodule

// ==== verification/tb_conv_core.sv ====
`timescale 1ns/100ps
`include "conv_config.svh"

module tb_conv_core import conv_pkg::*; ();

	localparam int TOTAL_PIX = 8*6 + 16*5 + 10*7 + 12*4 + 6*5;
	localparam int CYCLE_LIMIT = 4 * TOTAL_PIX + 200;
	localparam int DRAIN_LIMIT = 100; // cycles for the pipeline to empty after a frame

	logic    clk = 1'b0;
	logic    rst;
	logic    cfg_valid;
	reg_wr_t cfg;
	logic    s_valid;
	pixel_t  s_pix;
	logic    s_ready;
	logic    m_valid;
	feat_t   m_data;
	logic    m_last;
	logic    m_ready;

	int          k_w [9]; // kernel as loaded into the DUT
	int          k_a;
	int          k_b;
	int          k_c;
	int          img [0:6][0:15];
	logic [16:0] exp_q [$]; // {last, data}
	int          n_checks = 0;
	int          n_errors = 0;
	int          n_out = 0;
	int          n_last = 0;
	int          cycles = 0;
	logic        bp_mode = 1'b0;

	conv_core_top dut0 (
		.clk(clk),
		.rst(rst),
		.cfg_valid(cfg_valid),
		.cfg(cfg),
		.s_valid(s_valid),
		.s_pix(s_pix),
		.s_ready(s_ready),
		.m_valid(m_valid),
		.m_data(m_data),
		.m_last(m_last),
		.m_ready(m_ready)
	);

	always #2 clk = ~clk;

	// win[r*3+c], row 0 is the top row of the window
	function automatic logic signed [15:0] conv_ref(input int win [9]);
		longint acc;
		longint y;
		acc = 0;
		for (int i = 0; i < 9; i++) begin
			acc += longint'(k_w[i]) * longint'(win[i]);
		end
		acc = acc >>> `IN_FT_QUAZ_ACC;
		y = ((longint'(k_a) * acc) >>> `AB_QUAZ_ACC) + longint'(k_b);
		if (y < 0) begin
			y = (y * longint'(k_c)) >>> `C_QUAZ_ACC; // leaky slope
		end
		if (y > 32767) begin
			y = 32767;
		end else if (y < -32768) begin
			y = -32768;
		end
		return y[15:0];
	endfunction

	task automatic write_reg(input logic [3:0] addr, input int data);
		cfg.addr = addr;
		cfg.data = data[15:0];
		cfg_valid = 1'b1;
		@(posedge clk);
		#0.5;
		cfg_valid = 1'b0;
	endtask

	task automatic load_params(input int w);
		for (int i = 0; i < 9; i++) begin
			write_reg(4'(i), k_w[i]);
		end
		write_reg(REG_A, k_a);
		write_reg(REG_B, k_b);
		write_reg(REG_C, k_c);
		write_reg(REG_MAP_W, w - 1);
	endtask

	task automatic pick_random_params();
		for (int i = 0; i < 9; i++) begin
			k_w[i] = int'($urandom_range(0, 2047)) - 1024; // about -1.0 to 1.0
		end
		k_a = int'($urandom_range(4096, 12288));
		k_b = int'($urandom_range(0, 4095)) - 2048;
		k_c = int'($urandom_range(820, 8192));
	endtask

	// fills the image, queues the expected results, streams it and waits for the drain
	task automatic run_frame(input int w, input int h, input bit signed_pix, input bit gaps);
		int   win [9];
		int   out_start;
		int   last_start;
		int   drain;
		logic accepted;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				if (!signed_pix) begin
					img[y][x] = int'($urandom_range(0, 16383));
				end else if ($urandom_range(0, 3) == 0) begin
					img[y][x] = int'($urandom_range(0, 65535)) - 32768; // full range
				end else begin
					img[y][x] = int'($urandom_range(0, 4095)) - 2048;
				end
			end
		end
		for (int y = 2; y < h; y++) begin
			for (int x = 2; x < w; x++) begin
				for (int i = 0; i < 9; i++) begin
					win[i] = img[y-2+i/3][x-2+i%3];
				end
				exp_q.push_back({(y == h-1) && (x == w-1), conv_ref(win)});
			end
		end
		out_start = n_out;
		last_start = n_last;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				while (gaps && $urandom_range(0, 1) == 1) begin
					s_valid = 1'b0; // idle cycle on the input
					@(posedge clk);
					#0.5;
				end
				s_pix.data = img[y][x][15:0];
				s_pix.last = (y == h-1) && (x == w-1);
				s_valid = 1'b1;
				accepted = 1'b0;
				while (!accepted) begin
					@(negedge clk);
					accepted = s_ready;
					@(posedge clk);
					#0.5;
				end
			end
		end
		s_valid = 1'b0;
		drain = 0;
		while (exp_q.size() != 0 && drain < DRAIN_LIMIT) begin
			@(posedge clk);
			drain++;
		end
		repeat (8) @(posedge clk); // room for any extra output
		#0.5;
		assert (n_out - out_start == (w-2)*(h-2)) else begin
			$display("** Error at %0t ns: %0dx%0d frame gave %0d results, expected %0d",
				$time, w, h, n_out - out_start, (w-2)*(h-2));
			n_errors++;
		end
		assert (n_last - last_start == 1) else begin
			$display("** Error at %0t ns: %0dx%0d frame had %0d last flags, expected 1",
				$time, w, h, n_last - last_start);
			n_errors++;
		end
	endtask

	// output side, m_ready toggles only in the back-pressure test
	always @(posedge clk) begin
		#0.5;
		m_ready = bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
	end

	always @(negedge clk) begin
		logic [16:0] exp_word;
		if (!rst && m_valid && m_ready) begin
			n_out++;
			if (m_last) begin
				n_last++;
			end
			assert (exp_q.size() != 0) else begin
				$display("output %0d at %0t ns arrived with no result expected", m_data, $time);
				n_errors++;
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				n_checks++;
				assert (m_data === exp_word[15:0]) else begin
					$display("** Error at %0t ns: m_data %0d, expected %0d",
						$time, m_data, $signed(exp_word[15:0]));
					n_errors++;
				end
				assert (m_last === exp_word[16]) else begin
					$display("** Error at %0t ns: m_last %b, expected %b",
						$time, m_last, exp_word[16]);
					n_errors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles with %0d results still missing",
				cycles, exp_q.size());
			$display("checks %0d, errors %0d", n_checks, n_errors);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h41d1_ca4a));
		rst = 1'b1;
		cfg_valid = 1'b0;
		cfg = '0;
		s_valid = 1'b0;
		s_pix = '0;
		m_ready = 1'b1;
		repeat (3) @(posedge clk);
		#0.5;
		rst = 1'b0;

		assert (s_ready === 1'b0 && m_valid === 1'b0) else begin
			$display("** Error at %0t ns: s_ready %b m_valid %b after reset, expected 0",
				$time, s_ready, m_valid);
			n_errors++;
		end

		// identity kernel, centre weight 1.0
		k_w = '{0, 0, 0, 0, 1024, 0, 0, 0, 0};
		k_a = 4096;
		k_b = 0;
		k_c = 4096;
		load_params(8);
		repeat (2) @(posedge clk);
		#0.5;
		assert (s_ready === 1'b0) else begin
			$display("** Error at %0t ns: s_ready high before enable", $time);
			n_errors++;
		end
		write_reg(REG_EN, 1);
		assert (s_ready === 1'b1) else begin
			$display("** Error at %0t ns: s_ready low after enable", $time);
			n_errors++;
		end
		run_frame(8, 6, 1'b0, 1'b0);

		pick_random_params();
		load_params(16);
		run_frame(16, 5, 1'b1, 1'b0);

		pick_random_params();
		load_params(10);
		bp_mode = 1'b1;
		run_frame(10, 7, 1'b1, 1'b1);
		bp_mode = 1'b0;

		// two frames with width and kernel rewritten in between
		pick_random_params();
		load_params(12);
		run_frame(12, 4, 1'b1, 1'b0);
		pick_random_params();
		load_params(6);
		run_frame(6, 5, 1'b1, 1'b0);

		assert (exp_q.size() == 0) else begin
			$display("%0d expected results never came out of the core", exp_q.size());
			n_errors++;
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== conv_core_top.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_param_regs.sv
rtl/line_window_buffer.sv
rtl/conv_mac_3x3.sv
rtl/result_fifo.sv
rtl/linear_act_unit.sv
rtl/conv_core_top.sv
verification/tb_conv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the conv core testbench with Verilator, runs it, then checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_core \
	-f conv_core_top.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_conv_core > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } || exit 0
